// File: sim/idu_stim.txt
// name inst pc fetch_excp fetch_code exu_waddr lsu_waddr flush
// exp_excp exp_code exp_alu_op exp_imm exp_gpr_wen exp_mem_ren exp_mem_wen exp_stall
lui       123452b7 00000100 0 0 0 0 0 0 0 000 12345000 1 0 0 0
auipc     00001317 00000104 0 0 0 0 0 0 0 001 00001000 1 0 0 0
jal_fwd   008000ef 00000108 0 0 0 0 0 0 0 001 00000008 1 0 0 0
jal_back  ffdff0ef 0000010c 0 0 0 0 0 0 0 001 fffffffc 1 0 0 0
jalr      00c100e7 00000110 0 0 0 0 0 0 0 001 0000000c 1 0 0 0
beq       fe208ce3 00000114 0 0 0 0 0 0 0 001 fffffff8 0 0 0 0
bltu      0041e863 00000118 0 0 0 0 0 0 0 001 00000010 0 0 0 0
lw        ffc42383 0000011c 0 0 0 0 0 0 0 001 fffffffc 1 1 0 0
lbu_x0    00504483 00000120 0 0 0 0 0 0 0 001 00000005 1 1 0 0
sw        00a5aa23 00000124 0 0 0 0 0 0 0 001 00000014 0 0 1 0
sb_x0     fe008fa3 00000128 0 0 0 0 0 0 0 001 ffffffff 0 0 1 0
addi      fff10093 0000012c 0 0 0 0 0 0 0 001 ffffffff 1 0 0 0
slti      00722193 00000130 0 0 0 0 0 0 0 008 00000007 1 0 0 0
srai      40335293 00000134 0 0 0 0 0 0 0 080 00000403 1 0 0 0
add       003100b3 00000138 0 0 0 0 0 0 0 001 00000000 1 0 0 0
sub       40628233 0000013c 0 0 0 0 0 0 0 002 00000000 1 0 0 0
and       009473b3 00000140 0 0 0 0 0 0 0 200 00000000 1 0 0 0
ecall     00000073 00000144 0 0 0 0 0 1 b 000 00000000 0 0 0 0
ebreak    00100073 00000148 0 0 0 0 0 1 3 000 00000000 0 0 0 0
csrrw     300110f3 0000014c 0 0 0 0 0 1 2 000 00000000 0 0 0 0
mret      30200073 00000150 0 0 0 0 0 1 2 000 00000000 0 0 0 0
fence_i   0000100f 00000154 0 0 0 0 0 1 2 000 00000000 0 0 0 0
bad_opc   0000007f 00000158 0 0 0 0 0 1 2 000 00000000 0 0 0 0
bad_low   00000010 0000015c 0 0 0 0 0 1 2 001 00000000 0 0 0 0
fx_add    003100b3 00000160 1 1 0 0 0 1 1 001 00000000 1 0 0 0
fx_ecall  00000073 00000164 1 5 0 0 0 1 5 000 00000000 0 0 0 0
stall_exu 003100b3 00000168 0 0 3 0 0 0 0 001 00000000 1 0 0 1
stall_lsu ffc42383 0000016c 0 0 0 8 0 0 0 001 fffffffc 1 1 0 1
no_stall  123452b7 00000170 0 0 8 0 0 0 0 000 12345000 1 0 0 0
flush     fff10093 00000174 0 0 0 0 1 0 0 001 ffffffff 1 0 0 0
or_after  00c5e533 00000178 0 0 0 0 0 0 0 100 00000000 1 0 0 0

// File: project.f
+incdir+include
hdl/idu_pkg.sv
hdl/idu_pipe_reg.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/raw_hazard.sv
hdl/idu_top.sv
sim/clock_gen.sv
sim/tb_idu.sv

// File: Bender.yml
package:
  name: idu

export_include_dirs:
  - include

sources:
  - files:
      - hdl/idu_pkg.sv
      - hdl/idu_pipe_reg.sv
      - hdl/inst_decoder.sv
      - hdl/imm_gen.sv
      - hdl/raw_hazard.sv
      - hdl/idu_top.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/tb_idu.sv

// File: sim/tb_idu.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_config.svh"

module tb_idu;

  localparam int MAX_VECTORS  = 64;
  localparam int VALUE_W      = $bits(idu_pkg::decode_pkt_t);
  localparam int RESET_CYCLES = 16;
  localparam int VECTOR_CYCLES = 40;

  // one line of the stimulus file
  typedef struct packed {
    logic [`IDU_XLEN-1:0]        inst;
    logic [`IDU_XLEN-1:0]        pc;
    logic                        fetch_excp;
    logic [`IDU_EXCP_CODE_W-1:0] fetch_code;
    logic [`IDU_HAZ_ADDR_W-1:0]  exu_waddr;
    logic [`IDU_HAZ_ADDR_W-1:0]  lsu_waddr;
    logic                        flush;
    logic                        excp;
    logic [`IDU_EXCP_CODE_W-1:0] excp_code;
    logic [`IDU_ALU_OP_W-1:0]    alu_op;
    logic [`IDU_XLEN-1:0]        imm;
    logic                        gpr_wen;
    logic                        mem_ren;
    logic                        mem_wen;
    logic                        stall;
  } vector_t;

  logic                        clock;
  logic                        reset;
  logic                        fetch_valid;
  logic                        fetch_ready;
  idu_pkg::fetch_pkt_t         fetch_pkt;
  logic                        exu_valid;
  logic                        exu_ready;
  idu_pkg::decode_pkt_t        exu_pkt;
  logic [`IDU_GPR_ADDR_W-1:0]  gpr_raddr1;
  logic [`IDU_GPR_ADDR_W-1:0]  gpr_raddr2;
  logic [`IDU_XLEN-1:0]        gpr_rdata1;
  logic [`IDU_XLEN-1:0]        gpr_rdata2;
  logic [`IDU_HAZ_ADDR_W-1:0]  exu_gpr_waddr;
  logic [`IDU_HAZ_ADDR_W-1:0]  lsu_gpr_waddr;
  logic                        flush;

  vector_t     vectors [MAX_VECTORS];
  string       names [MAX_VECTORS];
  int          num_vectors;
  int          error_count;
  int          delivered = 0;
  int          expected_deliveries;
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = RESET_CYCLES + VECTOR_CYCLES * MAX_VECTORS;
  logic [31:0] rng_state;

  clock_gen #(
    .period_ns    (40),
    .reset_cycles (RESET_CYCLES)
  ) u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  idu_top UUT (
    .clock         (clock),
    .reset         (reset),
    .fetch_valid   (fetch_valid),
    .fetch_ready   (fetch_ready),
    .fetch_pkt     (fetch_pkt),
    .exu_valid     (exu_valid),
    .exu_ready     (exu_ready),
    .exu_pkt       (exu_pkt),
    .gpr_raddr1    (gpr_raddr1),
    .gpr_raddr2    (gpr_raddr2),
    .gpr_rdata1    (gpr_rdata1),
    .gpr_rdata2    (gpr_rdata2),
    .exu_gpr_waddr (exu_gpr_waddr),
    .lsu_gpr_waddr (lsu_gpr_waddr),
    .flush         (flush)
  );

  // ----------------------------------------------------------------------
  // register file model and helpers
  // ----------------------------------------------------------------------
  // x0 returns a non-zero word so that zeroing in the stage shows
  function automatic logic [31:0] rf_word(input logic [4:0] addr);
    return 32'h5a5a_0000 | {16'h0, 3'b0, addr, 3'b0, addr};
  endfunction

  function automatic logic [31:0] expected_rdata(input logic [4:0] addr);
    if (addr[3:0] == 4'd0) begin
      return '0;
    end
    return rf_word(addr);
  endfunction

  // unit flags from the full rv32i major opcode
  function automatic idu_pkg::exu_sel_t expected_exu_sel(input logic [31:0] inst);
    idu_pkg::exu_sel_t sel;
    sel = '0;
    case (inst[6:0])
      7'b1100011: sel.branch = 1'b1;
      7'b1101111: sel.jal    = 1'b1;
      7'b0110111: sel.lui    = 1'b1;
      7'b1100111: sel.jalr   = 1'b1;
      7'b0010111: sel.auipc  = 1'b1;
      7'b0110011: sel.reg_op = 1'b1;
      default:    sel        = '0;
    endcase
    return sel;
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  assign gpr_rdata1 = rf_word(gpr_raddr1);
  assign gpr_rdata2 = rf_word(gpr_raddr2);

  task automatic abort_run(input string reason);
    error_count++;
    $display("ERROR: %s", reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [VALUE_W-1:0] expected,
                             input logic [VALUE_W-1:0] actual);
    if (expected !== actual) begin
      error_count++;
      $display("MISMATCH %s %s expected %0h actual %0h", test, what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "first error reached");
    end
  endtask

  // bounded run length
  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      abort_run("timeout, the DUT did not get through the vectors in time");
    end
  end

  // every transfer to execute seen at the interface
  always @(posedge clock) begin
    if (!reset && exu_valid && exu_ready) begin
      delivered <= delivered + 1;
    end
  end

  // ----------------------------------------------------------------------
  // stimulus file
  // ----------------------------------------------------------------------
  task automatic load_vectors();
    int          fd;
    int          status;
    int          fields;
    string       line;
    string       name;
    logic [31:0] col [15];
    fd = $fopen("sim/idu_stim.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file sim/idu_stim.txt");
    end
    num_vectors = 0;
    while (!$feof(fd)) begin
      status = $fgets(line, fd);
      if (status == 0) begin
        break;
      end
      if (line.len() < 4 || line.substr(0, 1) == "//") begin
        continue;
      end
      fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                       col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                       col[8], col[9], col[10], col[11], col[12], col[13], col[14]);
      if (fields != 16) begin
        abort_run("a line of the stimulus file has the wrong number of columns");
      end
      if (num_vectors == MAX_VECTORS) begin
        abort_run("the stimulus file holds more vectors than the testbench can store");
      end
      names[num_vectors]              = name;
      vectors[num_vectors].inst       = col[0];
      vectors[num_vectors].pc         = col[1];
      vectors[num_vectors].fetch_excp = col[2][0];
      vectors[num_vectors].fetch_code = col[3][3:0];
      vectors[num_vectors].exu_waddr  = col[4][3:0];
      vectors[num_vectors].lsu_waddr  = col[5][3:0];
      vectors[num_vectors].flush      = col[6][0];
      vectors[num_vectors].excp       = col[7][0];
      vectors[num_vectors].excp_code  = col[8][3:0];
      vectors[num_vectors].alu_op     = col[9][9:0];
      vectors[num_vectors].imm        = col[10];
      vectors[num_vectors].gpr_wen    = col[11][0];
      vectors[num_vectors].mem_ren    = col[12][0];
      vectors[num_vectors].mem_wen    = col[13][0];
      vectors[num_vectors].stall      = col[14][0];
      num_vectors++;
    end
    $fclose(fd);
    if (num_vectors == 0) begin
      abort_run("the stimulus file holds no vectors");
    end
  endtask

  // ----------------------------------------------------------------------
  // per-vector sequences
  // ----------------------------------------------------------------------
  task automatic check_packet(input int idx);
    vector_t           v;
    string             n;
    idu_pkg::exu_sel_t sel;
    v   = vectors[idx];
    n   = names[idx];
    sel = expected_exu_sel(v.inst);
    check_value(n, "pc", v.pc, exu_pkt.pc);
    check_value(n, "imm", v.imm, exu_pkt.imm);
    check_value(n, "alu_op", v.alu_op, exu_pkt.alu_op);
    check_value(n, "exu_sel", sel, exu_pkt.exu_sel);
    // branch condition is the func3 field of the branch
    if (sel.branch) begin
      check_value(n, "branch_code", v.inst[14:12], exu_pkt.branch_code);
    end
    check_value(n, "gpr_wen", v.gpr_wen, exu_pkt.gpr_wen);
    check_value(n, "gpr_waddr", v.inst[11:7], exu_pkt.gpr_waddr);
    check_value(n, "mem_ren", v.mem_ren, exu_pkt.mem_ren);
    check_value(n, "mem_wen", v.mem_wen, exu_pkt.mem_wen);
    check_value(n, "excp", v.excp, exu_pkt.excp);
    check_value(n, "excp_code", v.excp_code, exu_pkt.excp_code);
    check_value(n, "gpr_raddr1", v.inst[19:15], gpr_raddr1);
    check_value(n, "gpr_raddr2", v.inst[24:20], gpr_raddr2);
    check_value(n, "rdata1", expected_rdata(v.inst[19:15]), exu_pkt.rdata1);
    check_value(n, "rdata2", expected_rdata(v.inst[24:20]), exu_pkt.rdata2);
  endtask

  // random back-pressure until execute takes the item
  task automatic deliver(input int idx);
    idu_pkg::decode_pkt_t snap;
    logic                 have_snap;
    logic                 done;
    have_snap = 1'b0;
    done      = 1'b0;
    while (!done) begin
      @(posedge clock);
      rng_state = xorshift32(rng_state);
      exu_ready <= rng_state[4];
      @(negedge clock);
      check_value(names[idx], "exu_valid", 1'b1, exu_valid);
      check_value(names[idx], "fetch_ready", 1'b0, fetch_ready);
      if (have_snap) begin
        check_value(names[idx], "held packet", snap, exu_pkt);
      end
      if (exu_ready) begin
        check_packet(idx);
        done = 1'b1;
      end else begin
        snap      = exu_pkt;
        have_snap = 1'b1;
      end
    end
    @(posedge clock);
    exu_ready <= 1'b0;
    @(negedge clock);
    check_value(names[idx], "exu_valid after transfer", 1'b0, exu_valid);
  endtask

  task automatic run_vector(input int idx);
    vector_t             v;
    idu_pkg::fetch_pkt_t pkt;
    v = vectors[idx];
    pkt.instruction = v.inst;
    pkt.pc          = v.pc;
    pkt.excp        = v.fetch_excp;
    pkt.excp_code   = v.fetch_code;

    @(negedge clock);
    while (!fetch_ready) begin
      @(negedge clock);
    end
    @(posedge clock);
    fetch_valid   <= 1'b1;
    fetch_pkt     <= pkt;
    exu_gpr_waddr <= v.exu_waddr;
    lsu_gpr_waddr <= v.lsu_waddr;
    exu_ready     <= 1'b0;
    // fetch transfer on this edge
    @(posedge clock);
    fetch_valid <= 1'b0;

    if (v.flush) begin
      flush <= 1'b1;
      @(negedge clock);
      check_value(names[idx], "exu_valid during flush", 1'b0, exu_valid);
      check_value(names[idx], "fetch_ready during flush", 1'b0, fetch_ready);
      @(posedge clock);
      flush <= 1'b0;
      @(negedge clock);
      check_value(names[idx], "exu_valid after flush", 1'b0, exu_valid);
      check_value(names[idx], "fetch_ready after flush", 1'b1, fetch_ready);
    end else begin
      if (v.stall) begin
        repeat (3) begin
          @(negedge clock);
          check_value(names[idx], "exu_valid during stall", 1'b0, exu_valid);
          check_value(names[idx], "fetch_ready during stall", 1'b0, fetch_ready);
        end
        // pending write retires
        @(posedge clock);
        exu_gpr_waddr <= '0;
        lsu_gpr_waddr <= '0;
      end else begin
        @(negedge clock);
        check_value(names[idx], "exu_valid latency", 1'b1, exu_valid);
      end
      deliver(idx);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    fetch_valid   = 1'b0;
    fetch_pkt     = '0;
    exu_ready     = 1'b0;
    exu_gpr_waddr = '0;
    lsu_gpr_waddr = '0;
    flush         = 1'b0;
    rng_state     = 32'd30;
    error_count   = 0;

    load_vectors();
    cycle_limit = RESET_CYCLES + VECTOR_CYCLES * num_vectors;
    expected_deliveries = 0;
    for (int i = 0; i < num_vectors; i++) begin
      if (!vectors[i].flush) begin
        expected_deliveries++;
      end
    end

    @(negedge clock);
    while (reset) begin
      @(negedge clock);
    end
    check_value("reset", "fetch_ready", 1'b1, fetch_ready);
    check_value("reset", "exu_valid", 1'b0, exu_valid);

    for (int i = 0; i < num_vectors; i++) begin
      run_vector(i);
    end
    check_value("summary", "deliveries", expected_deliveries, delivered);

    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
  parameter int unsigned period_ns    = 40,
  parameter int unsigned reset_cycles = 16
) (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  // reset released on a rising edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

`default_nettype wire

// File: hdl/idu_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_config.svh"

module idu_top (
  input  wire                         clock,
  input  wire                         reset,
  input  wire                         fetch_valid,
  output logic                        fetch_ready,
  input  idu_pkg::fetch_pkt_t         fetch_pkt,
  output logic                        exu_valid,
  input  wire                         exu_ready,
  output idu_pkg::decode_pkt_t        exu_pkt,
  output logic [`IDU_GPR_ADDR_W-1:0]  gpr_raddr1,
  output logic [`IDU_GPR_ADDR_W-1:0]  gpr_raddr2,
  input  wire  [`IDU_XLEN-1:0]        gpr_rdata1,
  input  wire  [`IDU_XLEN-1:0]        gpr_rdata2,
  input  wire  [`IDU_HAZ_ADDR_W-1:0]  exu_gpr_waddr,
  input  wire  [`IDU_HAZ_ADDR_W-1:0]  lsu_gpr_waddr,
  input  wire                         flush
);

  idu_pkg::fetch_pkt_t        held;
  idu_pkg::src_use_t          src;
  idu_pkg::alu_op_t           alu_op;
  idu_pkg::exu_sel_t          exu_sel;
  logic [`IDU_BR_CODE_W-1:0]   branch_code;
  logic                        gpr_wen;
  logic                        mem_ren;
  logic                        mem_wen;
  logic                        excp;
  logic [`IDU_EXCP_CODE_W-1:0] excp_code;
  logic [`IDU_IMM_FMT_W-1:0]   imm_fmt;
  logic [`IDU_XLEN-1:0]        imm;
  logic                        pending;
  logic                        stall;

  // ----------------------------------------------------------------------
  // stage register and decode
  // ----------------------------------------------------------------------
  idu_pipe_reg #(
    .payload_t (idu_pkg::fetch_pkt_t)
  ) u_pipe_reg (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (fetch_valid),
    .in_ready  (fetch_ready),
    .in_data   (fetch_pkt),
    .out_valid (exu_valid),
    .out_ready (exu_ready),
    .out_data  (held),
    .full      (pending),
    .stall     (stall),
    .flush     (flush)
  );

  inst_decoder u_decoder (
    .inst        (held.instruction),
    .fetch_excp  (held.excp),
    .fetch_code  (held.excp_code),
    .alu_op      (alu_op),
    .exu_sel     (exu_sel),
    .branch_code (branch_code),
    .gpr_wen     (gpr_wen),
    .mem_ren     (mem_ren),
    .mem_wen     (mem_wen),
    .excp        (excp),
    .excp_code   (excp_code),
    .src         (src),
    .imm_fmt     (imm_fmt)
  );

  imm_gen u_imm_gen (
    .inst    (held.instruction),
    .imm_fmt (imm_fmt),
    .imm     (imm)
  );

  raw_hazard u_raw_hazard (
    .src           (src),
    .pending       (pending),
    .flush         (flush),
    .exu_gpr_waddr (exu_gpr_waddr),
    .lsu_gpr_waddr (lsu_gpr_waddr),
    .stall         (stall)
  );

  // ----------------------------------------------------------------------
  // register file reads and output packet
  // ----------------------------------------------------------------------
  assign gpr_raddr1 = src.rs1;
  assign gpr_raddr2 = src.rs2;

  always_comb begin
    exu_pkt.pc          = held.pc;
    exu_pkt.imm         = imm;
    // x0 reads as zero whatever the register file returns
    exu_pkt.rdata1      = (src.rs1[`IDU_HAZ_ADDR_W-1:0] == '0) ? '0 : gpr_rdata1;
    exu_pkt.rdata2      = (src.rs2[`IDU_HAZ_ADDR_W-1:0] == '0) ? '0 : gpr_rdata2;
    exu_pkt.alu_op      = alu_op;
    exu_pkt.exu_sel     = exu_sel;
    exu_pkt.branch_code = branch_code;
    exu_pkt.gpr_wen     = gpr_wen;
    exu_pkt.gpr_waddr   = held.instruction[`IDU_RD_HI:`IDU_RD_LO];
    exu_pkt.mem_ren     = mem_ren;
    exu_pkt.mem_wen     = mem_wen;
    exu_pkt.excp        = excp;
    exu_pkt.excp_code   = excp_code;
  end

endmodule

`default_nettype wire

// File: hdl/raw_hazard.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_config.svh"

module raw_hazard (
  input  idu_pkg::src_use_t         src,
  input  wire                       pending,
  input  wire                       flush,
  input  wire [`IDU_HAZ_ADDR_W-1:0] exu_gpr_waddr,
  input  wire [`IDU_HAZ_ADDR_W-1:0] lsu_gpr_waddr,
  output logic                      stall
);

  logic [`IDU_HAZ_ADDR_W-1:0] rs1_idx;
  logic [`IDU_HAZ_ADDR_W-1:0] rs2_idx;
  logic                       rs1_hit;
  logic                       rs2_hit;

  // only 16 registers, compare on the low index bits
  assign rs1_idx = src.rs1[`IDU_HAZ_ADDR_W-1:0];
  assign rs2_idx = src.rs2[`IDU_HAZ_ADDR_W-1:0];

  // x0 never waits, an idle write address of zero never matches
  assign rs1_hit = src.reads_rs1 && (rs1_idx != '0)
                   && (rs1_idx == exu_gpr_waddr || rs1_idx == lsu_gpr_waddr);
  assign rs2_hit = src.reads_rs2 && (rs2_idx != '0)
                   && (rs2_idx == exu_gpr_waddr || rs2_idx == lsu_gpr_waddr);

  // flush kills the held item, nothing left to wait for
  assign stall = pending && (rs1_hit || rs2_hit) && !flush;

  // pending write addresses and flush must be driven while an item waits
  a_stall_known: assert final (pending !== 1'b1 || !$isunknown(stall))
    else $error("raw_hazard: stall unknown while an item is held");

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_config.svh"

module imm_gen (
  input  wire  [`IDU_XLEN-1:0]      inst,
  input  wire  [`IDU_IMM_FMT_W-1:0] imm_fmt,
  output logic [`IDU_XLEN-1:0]      imm
);

  logic sign;

  assign sign = inst[31];

  // bit scramble per base isa format
  always_comb begin
    case (imm_fmt)
      `IDU_IMM_I: begin
        imm = {{20{sign}}, inst[31:20]};
      end
      `IDU_IMM_S: begin
        imm = {{20{sign}}, inst[31:25], inst[11:7]};
      end
      `IDU_IMM_B: begin
        imm = {{20{sign}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      `IDU_IMM_U: begin
        imm = {inst[31:12], 12'b0};
      end
      `IDU_IMM_J: begin
        imm = {{12{sign}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: begin
        // r-type, system and fence carry no immediate
        imm = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/inst_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "idu_config.svh"

module inst_decoder (
  input  wire [`IDU_XLEN-1:0]         inst,
  input  wire                         fetch_excp,
  input  wire [`IDU_EXCP_CODE_W-1:0]  fetch_code,
  output idu_pkg::alu_op_t            alu_op,
  output idu_pkg::exu_sel_t           exu_sel,
  output logic [`IDU_BR_CODE_W-1:0]   branch_code,
  output logic                        gpr_wen,
  output logic                        mem_ren,
  output logic                        mem_wen,
  output logic                        excp,
  output logic [`IDU_EXCP_CODE_W-1:0] excp_code,
  output idu_pkg::src_use_t           src,
  output logic [`IDU_IMM_FMT_W-1:0]   imm_fmt
);

  // major opcodes, inst[6:2]
  localparam logic [4:0] OPC_LOAD     = 5'b00000;
  localparam logic [4:0] OPC_MISC_MEM = 5'b00011;
  localparam logic [4:0] OPC_OP_IMM   = 5'b00100;
  localparam logic [4:0] OPC_AUIPC    = 5'b00101;
  localparam logic [4:0] OPC_STORE    = 5'b01000;
  localparam logic [4:0] OPC_OP       = 5'b01100;
  localparam logic [4:0] OPC_LUI      = 5'b01101;
  localparam logic [4:0] OPC_BRANCH   = 5'b11000;
  localparam logic [4:0] OPC_JALR     = 5'b11001;
  localparam logic [4:0] OPC_JAL      = 5'b11011;
  localparam logic [4:0] OPC_SYSTEM   = 5'b11100;

  logic [4:0] opcode;
  logic [2:0] func3;
  logic [6:0] func7;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;

  logic op_load;
  logic op_misc_mem;
  logic op_imm;
  logic op_auipc;
  logic op_store;
  logic op_op;
  logic op_lui;
  logic op_branch;
  logic op_jalr;
  logic op_jal;
  logic op_system;

  logic f7_zero;
  logic f7_alt;
  logic is_ecall;
  logic is_ebreak;
  logic legal;
  logic illegal;

  assign opcode = inst[`IDU_OPCODE_HI:`IDU_OPCODE_LO];
  assign func3  = inst[`IDU_FUNC3_HI:`IDU_FUNC3_LO];
  assign func7  = inst[`IDU_FUNC7_HI:`IDU_FUNC7_LO];
  assign rd     = inst[`IDU_RD_HI:`IDU_RD_LO];
  assign rs1    = inst[`IDU_RS1_HI:`IDU_RS1_LO];
  assign rs2    = inst[`IDU_RS2_HI:`IDU_RS2_LO];

  assign op_load     = (opcode == OPC_LOAD);
  assign op_misc_mem = (opcode == OPC_MISC_MEM);
  assign op_imm      = (opcode == OPC_OP_IMM);
  assign op_auipc    = (opcode == OPC_AUIPC);
  assign op_store    = (opcode == OPC_STORE);
  assign op_op       = (opcode == OPC_OP);
  assign op_lui      = (opcode == OPC_LUI);
  assign op_branch   = (opcode == OPC_BRANCH);
  assign op_jalr     = (opcode == OPC_JALR);
  assign op_jal      = (opcode == OPC_JAL);
  assign op_system   = (opcode == OPC_SYSTEM);

  assign f7_zero = (func7 == 7'b0000000);
  assign f7_alt  = (func7 == 7'b0100000);

  // ----------------------------------------------------------------------
  // legality
  // ----------------------------------------------------------------------
  assign is_ecall  = op_system && f7_zero && rs2 == 5'd0 && rs1 == 5'd0
                     && func3 == 3'b000 && rd == 5'd0;
  assign is_ebreak = op_system && f7_zero && rs2 == 5'd1 && rs1 == 5'd0
                     && func3 == 3'b000 && rd == 5'd0;

  // csr ops, mret and fence.i fall through as illegal
  assign legal = op_lui || op_auipc || op_jal
              || (op_jalr && func3 == 3'b000)
              || (op_branch && func3 != 3'b010 && func3 != 3'b011)
              || (op_load && (func3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}))
              || (op_store && (func3 inside {3'b000, 3'b001, 3'b010}))
              || (op_imm && func3 == 3'b001 && f7_zero)
              || (op_imm && func3 == 3'b101 && (f7_zero || f7_alt))
              || (op_imm && func3 != 3'b001 && func3 != 3'b101)
              || (op_op && f7_zero)
              || (op_op && f7_alt && (func3 == 3'b000 || func3 == 3'b101))
              || (op_misc_mem && func3 == 3'b000)
              || is_ecall || is_ebreak;

  assign illegal = (inst[1:0] != 2'b11) || !legal;

  assign excp = fetch_excp || illegal || is_ecall || is_ebreak;

  always_comb begin
    if (fetch_excp) begin
      excp_code = fetch_code;
    end else if (illegal) begin
      excp_code = `IDU_EXCP_ILLEGAL;
    end else if (is_ecall) begin
      excp_code = `IDU_EXCP_ECALL;
    end else if (is_ebreak) begin
      excp_code = `IDU_EXCP_BREAKPOINT;
    end else begin
      excp_code = '0;
    end
  end

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  always_comb begin
    alu_op = '0;
    alu_op[idu_pkg::ALU_ADD]  = op_auipc || op_jal || op_jalr || op_load || op_store
                              || op_branch || (op_imm && func3 == 3'b000)
                              || (op_op && func3 == 3'b000 && !f7_alt);
    alu_op[idu_pkg::ALU_SUB]  = op_op && func3 == 3'b000 && f7_alt;
    alu_op[idu_pkg::ALU_SLL]  = (op_imm || op_op) && func3 == 3'b001;
    alu_op[idu_pkg::ALU_SLT]  = (op_imm || op_op) && func3 == 3'b010;
    alu_op[idu_pkg::ALU_SLTU] = (op_imm || op_op) && func3 == 3'b011;
    alu_op[idu_pkg::ALU_XOR]  = (op_imm || op_op) && func3 == 3'b100;
    alu_op[idu_pkg::ALU_SRL]  = (op_imm || op_op) && func3 == 3'b101 && !f7_alt;
    alu_op[idu_pkg::ALU_SRA]  = (op_imm || op_op) && func3 == 3'b101 && f7_alt;
    alu_op[idu_pkg::ALU_OR]   = (op_imm || op_op) && func3 == 3'b110;
    alu_op[idu_pkg::ALU_AND]  = (op_imm || op_op) && func3 == 3'b111;
  end

  assign exu_sel.branch = op_branch;
  assign exu_sel.jal    = op_jal;
  assign exu_sel.lui    = op_lui;
  assign exu_sel.jalr   = op_jalr;
  assign exu_sel.auipc  = op_auipc;
  assign exu_sel.reg_op = op_op;

  assign branch_code = func3;
  assign mem_ren     = op_load;
  assign mem_wen     = op_store;

  // register index wraps at 16 entries on rv32e
  assign gpr_wen = !(op_branch || op_store || op_system || op_misc_mem)
                   && (rd[`IDU_HAZ_ADDR_W-1:0] != '0);

  assign src.rs1       = rs1;
  assign src.rs2       = rs2;
  assign src.reads_rs1 = op_jalr || op_branch || op_load || op_store || op_imm || op_op;
  assign src.reads_rs2 = op_branch || op_store || op_op;

  always_comb begin
    if (op_jalr || op_load || op_imm) begin
      imm_fmt = `IDU_IMM_I;
    end else if (op_store) begin
      imm_fmt = `IDU_IMM_S;
    end else if (op_branch) begin
      imm_fmt = `IDU_IMM_B;
    end else if (op_lui || op_auipc) begin
      imm_fmt = `IDU_IMM_U;
    end else if (op_jal) begin
      imm_fmt = `IDU_IMM_J;
    end else begin
      imm_fmt = `IDU_IMM_NONE;
    end
  end

  a_alu_onehot: assert final ($onehot0(alu_op))
    else $error("inst_decoder: more than one alu_op bit set");

endmodule

`default_nettype wire

// File: hdl/idu_pipe_reg.sv
`timescale 1ns/10ps
`default_nettype none

module idu_pipe_reg #(
  parameter type payload_t = logic
) (
  input  wire      clock,
  input  wire      reset,
  input  wire      in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  wire      out_ready,
  output payload_t out_data,
  output logic     full,
  input  wire      stall,
  input  wire      flush
);

  logic in_fire;
  logic out_fire;

  // ----------------------------------------------------------------------
  // handshake
  // ----------------------------------------------------------------------
  // one entry only, so a new item waits until the held one leaves
  assign in_ready  = !full && !stall;
  assign out_valid = full && !stall && !flush;

  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_fire) begin
      full <= 1'b1;
    end else if (out_fire || flush) begin
      // flush drops the held item
      full <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // payload
  // ----------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (in_fire) begin
      out_data <= in_data;
    end
  end

  // packet must hold while execute applies back-pressure
  a_hold_stable: assert property (
    @(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_data)
  ) else $error("idu_pipe_reg: payload changed under back-pressure");

  // an offered item was loaded from a known fetch packet
  a_known_payload: assert property (
    @(posedge clock) disable iff (reset)
    out_valid |-> !$isunknown(out_data)
  ) else $error("idu_pipe_reg: unknown payload offered to execute");

endmodule

`default_nettype wire

// File: hdl/idu_pkg.sv
`default_nettype none

`include "idu_config.svh"

package idu_pkg;

  // ----------------------------------------------------------------------
  // alu operation, one bit per function
  // ----------------------------------------------------------------------
  typedef logic [`IDU_ALU_OP_W-1:0] alu_op_t;

  // add also covers address and branch target computation
  localparam int unsigned ALU_ADD  = 0;
  localparam int unsigned ALU_SUB  = 1;
  localparam int unsigned ALU_SLL  = 2;
  localparam int unsigned ALU_SLT  = 3;
  localparam int unsigned ALU_SLTU = 4;
  localparam int unsigned ALU_XOR  = 5;
  localparam int unsigned ALU_SRL  = 6;
  localparam int unsigned ALU_SRA  = 7;
  localparam int unsigned ALU_OR   = 8;
  localparam int unsigned ALU_AND  = 9;

  // how execute uses its operands
  typedef struct packed {
    logic branch;
    logic jal;
    logic lui;
    logic jalr;
    logic auipc;
    logic reg_op;
  } exu_sel_t;

  // ----------------------------------------------------------------------
  // stage packets
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`IDU_XLEN-1:0]        instruction;
    logic [`IDU_XLEN-1:0]        pc;
    logic                        excp;
    logic [`IDU_EXCP_CODE_W-1:0] excp_code;
  } fetch_pkt_t;

  typedef struct packed {
    logic [`IDU_XLEN-1:0]        pc;
    logic [`IDU_XLEN-1:0]        imm;
    logic [`IDU_XLEN-1:0]        rdata1;
    logic [`IDU_XLEN-1:0]        rdata2;
    alu_op_t                     alu_op;
    exu_sel_t                    exu_sel;
    logic [`IDU_BR_CODE_W-1:0]   branch_code;
    logic                        gpr_wen;
    logic [`IDU_GPR_ADDR_W-1:0]  gpr_waddr;
    logic                        mem_ren;
    logic                        mem_wen;
    logic                        excp;
    logic [`IDU_EXCP_CODE_W-1:0] excp_code;
  } decode_pkt_t;

  // source registers of the held instruction, for the hazard check
  typedef struct packed {
    logic [`IDU_GPR_ADDR_W-1:0] rs1;
    logic [`IDU_GPR_ADDR_W-1:0] rs2;
    logic                       reads_rs1;
    logic                       reads_rs2;
  } src_use_t;

endpackage

`default_nettype wire

// File: include/idu_config.svh
`ifndef IDU_CONFIG_SVH
`define IDU_CONFIG_SVH

// datapath widths
`define IDU_XLEN         32
`define IDU_GPR_ADDR_W   5
// rv32e has 16 registers, so the low four index bits select the entry
`define IDU_HAZ_ADDR_W   4
`define IDU_EXCP_CODE_W  4
`define IDU_ALU_OP_W     10
`define IDU_BR_CODE_W    3
`define IDU_IMM_FMT_W    3

// exception cause codes
`define IDU_EXCP_ILLEGAL     4'd2
`define IDU_EXCP_BREAKPOINT  4'd3
`define IDU_EXCP_ECALL       4'd11

// instruction field positions
`define IDU_OPCODE_HI  6
`define IDU_OPCODE_LO  2
`define IDU_RD_HI      11
`define IDU_RD_LO      7
`define IDU_FUNC3_HI   14
`define IDU_FUNC3_LO   12
`define IDU_RS1_HI     19
`define IDU_RS1_LO     15
`define IDU_RS2_HI     24
`define IDU_RS2_LO     20
`define IDU_FUNC7_HI   31
`define IDU_FUNC7_LO   25

// immediate format select
`define IDU_IMM_NONE  3'd0
`define IDU_IMM_I     3'd1
`define IDU_IMM_S     3'd2
`define IDU_IMM_B     3'd3
`define IDU_IMM_U     3'd4
`define IDU_IMM_J     3'd5

`endif
